// ==== test/rx_frame_patterns.txt ====
# name beats padbytes data_base(hex) stall(none/random/hold) drop(1 = dropped whole)
# Hold frames are kept while stored beats plus own beats stay within 16
len1_pad3 1 3 00001000 none 0
len2_pad0 2 0 00002000 none 0
len3_pad1 3 1 00003000 none 0
len4_pad2 4 2 00004000 none 0
len5_pad0 5 0 00005000 none 0
len6_pad3 6 3 00006000 none 0
len7_pad1 7 1 00007000 none 0
len8_pad2 8 2 00008000 none 0
big20_drop 20 0 00020000 none 1
after_big 3 1 00021000 none 0
single_a 1 0 00031000 none 0
single_b 1 1 00032000 none 0
single_c 1 2 00033000 none 0
rand_a 4 0 00041000 random 0
rand_b 7 2 00042000 random 0
rand_c 1 3 00043000 random 0
rand_d 8 1 00044000 random 0
hold_a 5 1 00051000 hold 0
hold_b 6 0 00052000 hold 0
hold_c 4 2 00053000 hold 0
hold_d 3 0 00054000 hold 1
hold_e 1 3 00055000 hold 0
hold_f 2 1 00056000 hold 1
final_c 2 0 00061000 none 0

// ==== build.f ====
+incdir+common
common/rx_pkg.sv
common/rx_beat_if.sv
pkt_queue/pkt_fifo.sv
pkt_queue/pkt_queue_ctrl.sv
startframe_convert/startframe_convert.sv
verilog/frame_size_attach.sv
verilog/rx_frame_path.sv
test/rx_frame_path_assertions.sv
test/rx_frame_path_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module rx_frame_path_tb -o rx_sim

output=$(./obj_dir/rx_sim) || true
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== test/rx_frame_path_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_settings.svh"

module rx_frame_path_tb;

    localparam int TIMEOUT = 300;
    localparam int MAX_TESTS = 32;

    typedef struct packed {
        logic [7:0]                     test;
        logic [`RX_DATA_W-1:0]          data;
        logic                           sf;
        logic                           ef;
        logic [`RX_PADBYTES_W-1:0]      pad;
        logic [`RX_FRAME_SIZE_W-1:0]    size;
    } exp_beat_t;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           mac_val_i;
    logic [`RX_DATA_W-1:0]          mac_data_i;
    logic                           mac_last_i;
    logic [`RX_PADBYTES_W-1:0]      mac_padbytes_i;
    logic                           mac_rdy_o;
    logic                           eng_val_o;
    logic [`RX_DATA_W-1:0]          eng_data_o;
    logic                           eng_startframe_o;
    logic                           eng_endframe_o;
    logic [`RX_PADBYTES_W-1:0]      eng_padbytes_o;
    logic [`RX_FRAME_SIZE_W-1:0]    eng_frame_size_o;
    logic                           eng_rdy_i;

    string                          names [MAX_TESTS];
    int                             beats [MAX_TESTS];
    logic [`RX_PADBYTES_W-1:0]      pads [MAX_TESTS];
    logic [`RX_DATA_W-1:0]          bases [MAX_TESTS];
    string                          modes [MAX_TESTS];
    int                             drops [MAX_TESTS];
    int                             errs [MAX_TESTS];
    bit                             sent [MAX_TESTS];
    exp_beat_t                      model [$];
    int                             n_tests = 0;
    int                             n_pass = 0;
    int                             n_fail = 0;
    int                             stray = 0;
    bit                             aborted = 1'b0;
    bit                             group_sent = 1'b0;

    rx_frame_path rx_frame_path_inst (.*);

    always #5 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_patterns();
        int fd;
        string line;
        string nm;
        string md;
        int nb;
        int dr;
        logic [`RX_PADBYTES_W-1:0] pd;
        logic [`RX_DATA_W-1:0] bs;
        fd = $fopen("test/rx_frame_patterns.txt", "r");
        if (fd == 0) begin
            $display("The pattern file could not be opened");
            aborted = 1'b1;
            return;
        end
        while ($fgets(line, fd) > 0 && n_tests < MAX_TESTS) begin
            // Comment lines stop scanning after the first field
            if ($sscanf(line, "%s %d %d %h %s %d", nm, nb, pd, bs, md, dr) == 6) begin
                names[n_tests] = nm;
                beats[n_tests] = nb;
                pads[n_tests] = pd;
                bases[n_tests] = bs;
                modes[n_tests] = md;
                drops[n_tests] = dr;
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic report_test(input int t);
        if (errs[t] == 0) begin
            $display("PASS %s", names[t]);
            n_pass++;
        end else begin
            $display("FAIL %s with %0d errors", names[t], errs[t]);
            n_fail++;
        end
    endtask

    // A beat out of a frame that should be gone counts against that frame
    task automatic match_dropped(input logic [`RX_DATA_W-1:0] data);
        int i;
        for (i = 0; i < n_tests; i++) begin
            if (drops[i] != 0 && data >= bases[i]
                    && data < bases[i] + `RX_DATA_W'(beats[i])) begin
                $display("A beat of %s came out though its frame should be dropped", names[i]);
                errs[i]++;
            end
        end
    endtask

    task automatic send_frame(input int t);
        int k;
        int idle;
        exp_beat_t e;
        if (drops[t] == 0) begin
            for (k = 0; k < beats[t]; k++) begin
                e.test = 8'(t);
                e.data = bases[t] + `RX_DATA_W'(k);
                e.sf = (k == 0);
                e.ef = (k == beats[t] - 1);
                e.pad = e.ef ? pads[t] : '0;
                e.size = `RX_FRAME_SIZE_W'(beats[t] * `RX_DATA_BYTES)
                       - `RX_FRAME_SIZE_W'(pads[t]);
                model.push_back(e);
            end
        end
        for (k = 0; k < beats[t] && !aborted; k++) begin
            mac_val_i = 1'b1;
            mac_data_i = bases[t] + `RX_DATA_W'(k);
            mac_last_i = (k == beats[t] - 1);
            mac_padbytes_i = mac_last_i ? pads[t] : '0;
            idle = 0;
            while (!mac_rdy_o && !aborted) begin
                next_cycle();
                idle++;
                if (idle > TIMEOUT) begin
                    $display("Timeout: the MAC side was never ready for %s", names[t]);
                    aborted = 1'b1;
                end
            end
            next_cycle();
        end
        mac_val_i = 1'b0;
        sent[t] = 1'b1;
    endtask

    task automatic send_group(input int first, input int last_t);
        int t;
        int idle;
        for (t = first; t <= last_t && !aborted; t++) begin
            // Stalled reader drains slowly, so one frame at a time
            idle = 0;
            while (modes[t] == "random" && model.size() != 0 && !aborted) begin
                next_cycle();
                idle++;
                if (idle > TIMEOUT) begin
                    $display("Timeout: frames before %s were never read out", names[t]);
                    aborted = 1'b1;
                end
            end
            send_frame(t);
        end
        group_sent = 1'b1;
    endtask

    task automatic check_beat();
        exp_beat_t e;
        int t;
        match_dropped(eng_data_o);
        if (model.size() == 0) begin
            $display("A beat came out that belongs to no expected frame");
            stray++;
            return;
        end
        e = model.pop_front();
        t = int'(e.test);
        if (e.sf && !sent[t]) begin
            $display("Output of %s began before its last beat was sent", names[t]);
            errs[t]++;
        end
        if (eng_data_o !== e.data) begin
            $display("ERR %s data expected %h actual %h", names[t], e.data, eng_data_o);
            errs[t]++;
        end
        if ({eng_startframe_o, eng_endframe_o} !== {e.sf, e.ef}) begin
            $display("ERR %s start/end expected %b actual %b", names[t],
                     {e.sf, e.ef}, {eng_startframe_o, eng_endframe_o});
            errs[t]++;
        end
        if (eng_padbytes_o !== e.pad) begin
            $display("ERR %s padbytes expected %0d actual %0d", names[t], e.pad, eng_padbytes_o);
            errs[t]++;
        end
        if (e.sf && eng_frame_size_o !== e.size) begin
            $display("ERR %s frame size expected %0d actual %0d", names[t],
                     e.size, eng_frame_size_o);
            errs[t]++;
        end
        if (e.ef) begin
            report_test(t);
        end
    endtask

    task automatic read_frames(input string mode, input int n_expect);
        int got;
        int idle;
        int hold_left;
        got = 0;
        idle = 0;
        hold_left = 4;
        while (got < n_expect && !aborted) begin
            if (mode == "hold" && hold_left > 0) begin
                eng_rdy_i = 1'b0;
                if (group_sent) begin
                    hold_left--;
                end
            end else if (mode == "random") begin
                eng_rdy_i = ($urandom % 3) != 0;
            end else begin
                eng_rdy_i = 1'b1;
            end
            if (eng_val_o && eng_rdy_i) begin
                check_beat();
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    $display("Timeout: the engine side got no beat for %0d cycles", TIMEOUT);
                    aborted = 1'b1;
                end
            end
            next_cycle();
        end
    endtask

    initial begin
        int first;
        int last_t;
        int t;
        int n_expect;
        int reset_errs;
        rst = 1'b1;
        mac_val_i = 1'b0;
        mac_data_i = '0;
        mac_last_i = 1'b0;
        mac_padbytes_i = '0;
        eng_rdy_i = 1'b0;
        reset_errs = 0;
        void'($urandom(63732));
        load_patterns();
        if (n_tests == 0 && !aborted) begin
            $display("No test patterns were read");
            aborted = 1'b1;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Path stays idle with nothing sent
        repeat (3) begin
            if (eng_val_o !== 1'b0) begin
                $display("ERR after_reset eng_val_o expected 0 actual %b", eng_val_o);
                reset_errs++;
            end
            if (mac_rdy_o !== 1'b1) begin
                $display("ERR after_reset mac_rdy_o expected 1 actual %b", mac_rdy_o);
                reset_errs++;
            end
            next_cycle();
        end
        if (reset_errs == 0) begin
            $display("PASS after_reset");
            n_pass++;
        end else begin
            $display("FAIL after_reset with %0d errors", reset_errs);
            n_fail++;
        end

        // Consecutive lines with the same stall mode form one group
        first = 0;
        while (first < n_tests && !aborted) begin
            last_t = first;
            while (last_t + 1 < n_tests && modes[last_t + 1] == modes[first]) begin
                last_t++;
            end
            n_expect = 0;
            for (t = first; t <= last_t; t++) begin
                if (drops[t] == 0) begin
                    n_expect += beats[t];
                end
            end
            group_sent = 1'b0;
            fork
                send_group(first, last_t);
                read_frames(modes[first], n_expect);
            join
            eng_rdy_i = 1'b0;
            repeat (3) next_cycle();
            if (eng_val_o && !aborted) begin
                $display("A beat is still waiting after all kept frames of %s", names[first]);
                match_dropped(eng_data_o);
                stray++;
            end
            for (t = first; t <= last_t; t++) begin
                if (drops[t] != 0) begin
                    report_test(t);
                end
            end
            first = last_t + 1;
        end

        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && stray == 0 && !aborted) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/rx_frame_path_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_settings.svh"

module rx_frame_path_assertions (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           eng_val_o,
    input  wire logic [`RX_DATA_W-1:0]          eng_data_o,
    input  wire logic                           eng_startframe_o,
    input  wire logic                           eng_endframe_o,
    input  wire logic [`RX_PADBYTES_W-1:0]      eng_padbytes_o,
    input  wire logic [`RX_FRAME_SIZE_W-1:0]    eng_frame_size_o,
    input  wire logic                           eng_rdy_i
);

    // Beat under stall stays put until taken
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        eng_val_o && !eng_rdy_i |=> eng_val_o && $stable(eng_data_o)
            && $stable(eng_startframe_o) && $stable(eng_endframe_o)
            && $stable(eng_padbytes_o))
        else $error("engine beat changed while stalled");

    size_nonzero: assert property (@(posedge clk) disable iff (rst)
        eng_val_o && eng_startframe_o |-> eng_frame_size_o != '0)
        else $error("zero frame size on a first beat");

    reset_idle: assert property (@(posedge clk) rst |=> !eng_val_o)
        else $error("engine valid high after reset");

endmodule

bind rx_frame_path rx_frame_path_assertions rx_frame_path_assertions_inst (
    .clk                (clk),
    .rst                (rst),
    .eng_val_o          (eng_val_o),
    .eng_data_o         (eng_data_o),
    .eng_startframe_o   (eng_startframe_o),
    .eng_endframe_o     (eng_endframe_o),
    .eng_padbytes_o     (eng_padbytes_o),
    .eng_frame_size_o   (eng_frame_size_o),
    .eng_rdy_i          (eng_rdy_i)
);

`default_nettype wire

// ==== verilog/rx_frame_path.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_settings.svh"

module rx_frame_path (
    input  wire logic                       clk,
    input  wire logic                       rst,

    input  wire logic                       mac_val_i,
    input  wire logic [`RX_DATA_W-1:0]      mac_data_i,
    input  wire logic                       mac_last_i,
    input  wire logic [`RX_PADBYTES_W-1:0]  mac_padbytes_i,
    output logic                            mac_rdy_o,

    output logic                            eng_val_o,
    output logic [`RX_DATA_W-1:0]           eng_data_o,
    output logic                            eng_startframe_o,
    output logic                            eng_endframe_o,
    output logic [`RX_PADBYTES_W-1:0]       eng_padbytes_o,
    output logic [`RX_FRAME_SIZE_W-1:0]     eng_frame_size_o,
    input  wire logic                       eng_rdy_i
);

    rx_beat_if sf_beat ();
    rx_beat_if q_beat ();

    logic                           size_rd_req;
    logic                           size_empty;
    logic [`RX_FRAME_SIZE_W-1:0]    size_rd_data;

    startframe_convert startframe_convert_inst (
        .clk            (clk),
        .rst            (rst),
        .mac_val_i      (mac_val_i),
        .mac_data_i     (mac_data_i),
        .mac_last_i     (mac_last_i),
        .mac_padbytes_i (mac_padbytes_i),
        .mac_rdy_o      (mac_rdy_o),
        .dst_o          (sf_beat.src)
    );

    pkt_queue_ctrl pkt_queue_ctrl_inst (
        .clk            (clk),
        .rst            (rst),
        .wr_i           (sf_beat.dst),
        .rd_o           (q_beat.src),
        .size_rd_req_i  (size_rd_req),
        .size_empty_o   (size_empty),
        .size_rd_data_o (size_rd_data)
    );

    frame_size_attach frame_size_attach_inst (
        .q_i                (q_beat.dst),
        .size_rd_req_o      (size_rd_req),
        .size_empty_i       (size_empty),
        .size_rd_data_i     (size_rd_data),
        .eng_val_o          (eng_val_o),
        .eng_data_o         (eng_data_o),
        .eng_startframe_o   (eng_startframe_o),
        .eng_endframe_o     (eng_endframe_o),
        .eng_padbytes_o     (eng_padbytes_o),
        .eng_frame_size_o   (eng_frame_size_o),
        .eng_rdy_i          (eng_rdy_i)
    );

endmodule

`default_nettype wire

// ==== verilog/frame_size_attach.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_settings.svh"

module frame_size_attach (
    rx_beat_if.dst                          q_i,

    output logic                            size_rd_req_o,
    input  wire logic                       size_empty_i,
    input  wire logic [`RX_FRAME_SIZE_W-1:0] size_rd_data_i,

    output logic                            eng_val_o,
    output logic [`RX_DATA_W-1:0]           eng_data_o,
    output logic                            eng_startframe_o,
    output logic                            eng_endframe_o,
    output logic [`RX_PADBYTES_W-1:0]       eng_padbytes_o,
    output logic [`RX_FRAME_SIZE_W-1:0]     eng_frame_size_o,
    input  wire logic                       eng_rdy_i
);

    logic start_xfer;

    assign eng_val_o = q_i.val;
    assign eng_data_o = q_i.data;
    assign eng_startframe_o = q_i.startframe;
    assign eng_endframe_o = q_i.endframe;
    assign eng_padbytes_o = q_i.padbytes;
    assign q_i.rdy = eng_rdy_i;

    // Size of the waiting frame sits at the FIFO head
    assign eng_frame_size_o = size_rd_data_i;

    // A committed frame always has its size queued
    assign start_xfer = q_i.val & q_i.startframe & eng_rdy_i;
    assign size_rd_req_o = start_xfer & ~size_empty_i;

endmodule

`default_nettype wire

// ==== startframe_convert/startframe_convert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_settings.svh"

module startframe_convert (
    input  wire logic                       clk,
    input  wire logic                       rst,

    input  wire logic                       mac_val_i,
    input  wire logic [`RX_DATA_W-1:0]      mac_data_i,
    input  wire logic                       mac_last_i,
    input  wire logic [`RX_PADBYTES_W-1:0]  mac_padbytes_i,
    output logic                            mac_rdy_o,

    rx_beat_if.src                          dst_o
);

    logic                       out_val;
    logic [`RX_DATA_W-1:0]      out_data;
    logic                       out_startframe;
    logic                       out_endframe;
    logic [`RX_PADBYTES_W-1:0]  out_padbytes;
    logic                       expect_start;
    logic                       accept;

    // Register is free when empty or being drained this cycle
    assign mac_rdy_o = ~out_val | dst_o.rdy;
    assign accept = mac_val_i & mac_rdy_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_val <= 1'b0;
            expect_start <= 1'b1;
        end else begin
            if (mac_rdy_o) begin
                out_val <= mac_val_i;
            end
            // Next beat after a last beat opens a new frame
            if (accept) begin
                expect_start <= mac_last_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= mac_data_i;
            out_startframe <= expect_start;
            out_endframe <= mac_last_i;
            out_padbytes <= mac_padbytes_i;
        end
    end

    assign dst_o.val = out_val;
    assign dst_o.data = out_data;
    assign dst_o.startframe = out_startframe;
    assign dst_o.endframe = out_endframe;
    assign dst_o.padbytes = out_padbytes;

endmodule

`default_nettype wire

// ==== pkt_queue/pkt_queue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_settings.svh"

module pkt_queue_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst,

    rx_beat_if.dst                          wr_i,
    rx_beat_if.src                          rd_o,

    input  wire logic                       size_rd_req_i,
    output logic                            size_empty_o,
    output logic [`RX_FRAME_SIZE_W-1:0]     size_rd_data_o
);

    localparam int LOG_ELS = `RX_QUEUE_LOG_ELS;
    localparam int ELS = 1 << LOG_ELS;
    localparam int FSW = `RX_FRAME_SIZE_W;

    rx_pkg::queue_entry_t       mem [ELS];
    rx_pkg::queue_entry_t       wr_entry;
    rx_pkg::queue_entry_t       rd_entry;

    // Extra MSB tells full from empty
    logic [LOG_ELS:0]           rd_ptr;
    logic [LOG_ELS:0]           commit_ptr;
    logic [LOG_ELS:0]           tent_ptr;
    logic [FSW-1:0]             byte_cnt;
    logic [FSW-1:0]             frame_size;
    logic                       dropping;

    logic                       mem_full;
    logic                       size_full;
    logic                       overflow;
    logic                       store;
    logic                       size_push;
    logic                       rd_xfer;

    // No back-pressure, overflow drops the frame instead
    assign wr_i.rdy = 1'b1;

    assign wr_entry.data = wr_i.data;
    assign wr_entry.startframe = wr_i.startframe;
    assign wr_entry.endframe = wr_i.endframe;
    assign wr_entry.padbytes = wr_i.padbytes;

    assign mem_full = (tent_ptr[LOG_ELS] != rd_ptr[LOG_ELS])
                    && (tent_ptr[LOG_ELS-1:0] == rd_ptr[LOG_ELS-1:0]);
    assign overflow = mem_full | (wr_i.endframe & size_full);
    assign store = wr_i.val & ~dropping & ~overflow;
    assign size_push = store & wr_i.endframe;

    assign frame_size = byte_cnt + FSW'(`RX_DATA_BYTES) - FSW'(wr_i.padbytes);

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_ptr <= '0;
            tent_ptr <= '0;
            byte_cnt <= '0;
            dropping <= 1'b0;
        end else if (wr_i.val) begin
            if (dropping) begin
                // Discard until the frame ends
                dropping <= ~wr_i.endframe;
            end else if (overflow) begin
                tent_ptr <= commit_ptr;
                byte_cnt <= '0;
                dropping <= ~wr_i.endframe;
            end else begin
                tent_ptr <= tent_ptr + 1'b1;
                if (wr_i.endframe) begin
                    commit_ptr <= tent_ptr + 1'b1;
                    byte_cnt <= '0;
                end else begin
                    byte_cnt <= byte_cnt + FSW'(`RX_DATA_BYTES);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            mem[tent_ptr[LOG_ELS-1:0]] <= wr_entry;
        end
    end

    // Reader only sees committed frames
    assign rd_entry = mem[rd_ptr[LOG_ELS-1:0]];
    assign rd_o.val = (rd_ptr != commit_ptr);
    assign rd_o.data = rd_entry.data;
    assign rd_o.startframe = rd_entry.startframe;
    assign rd_o.endframe = rd_entry.endframe;
    assign rd_o.padbytes = rd_entry.padbytes;
    assign rd_xfer = rd_o.val & rd_o.rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_xfer) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    pkt_fifo #(
        .WIDTH      (FSW),
        .LOG_ELS    (`RX_SIZE_QUEUE_LOG_ELS)
    ) size_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_req_i   (size_push),
        .wr_data_i  (frame_size),
        .rd_req_i   (size_rd_req_i),
        .full_o     (size_full),
        .empty_o    (size_empty_o),
        .rd_data_o  (size_rd_data_o)
    );

endmodule

`default_nettype wire

// ==== pkt_queue/pkt_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_fifo #(
    parameter int WIDTH = 8,
    parameter int LOG_ELS = 4
) (
    input  wire logic               clk,
    input  wire logic               rst,

    input  wire logic               wr_req_i,
    input  wire logic [WIDTH-1:0]   wr_data_i,
    input  wire logic               rd_req_i,

    output logic                    full_o,
    output logic                    empty_o,
    output logic [WIDTH-1:0]        rd_data_o
);

    localparam int ELS = 1 << LOG_ELS;

    logic [WIDTH-1:0]   mem [ELS];
    logic [LOG_ELS:0]   wr_ptr;
    logic [LOG_ELS:0]   rd_ptr;
    logic               do_wr;
    logic               do_rd;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o = (wr_ptr[LOG_ELS] != rd_ptr[LOG_ELS])
                  && (wr_ptr[LOG_ELS-1:0] == rd_ptr[LOG_ELS-1:0]);
    assign do_wr = wr_req_i & ~full_o;
    assign do_rd = rd_req_i & ~empty_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[LOG_ELS-1:0]] <= wr_data_i;
        end
    end

    // Head of queue
    assign rd_data_o = mem[rd_ptr[LOG_ELS-1:0]];

endmodule

`default_nettype wire

// ==== common/rx_beat_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rx_settings.svh"

interface rx_beat_if;

    logic                       val;
    logic [`RX_DATA_W-1:0]      data;
    logic                       startframe;
    logic                       endframe;
    logic [`RX_PADBYTES_W-1:0]  padbytes;
    logic                       rdy;

    modport src (
        output val,
        output data,
        output startframe,
        output endframe,
        output padbytes,
        input  rdy
    );

    modport dst (
        input  val,
        input  data,
        input  startframe,
        input  endframe,
        input  padbytes,
        output rdy
    );

endinterface

`default_nettype wire

// ==== common/rx_pkg.sv ====
`default_nettype none

`include "rx_settings.svh"

package rx_pkg;

    // One beat as stored in the packet queue
    typedef struct packed {
        logic [`RX_DATA_W-1:0]      data;
        logic                       startframe;
        logic                       endframe;
        logic [`RX_PADBYTES_W-1:0]  padbytes;
    } queue_entry_t;

endpackage

`default_nettype wire

// ==== common/rx_settings.svh ====
`ifndef RX_SETTINGS_SVH
`define RX_SETTINGS_SVH

// MAC beat format
`define RX_DATA_W               32
`define RX_DATA_BYTES           4
`define RX_PADBYTES_W           2

// Packet queue holds 2**RX_QUEUE_LOG_ELS beats
`define RX_QUEUE_LOG_ELS        4
`define RX_SIZE_QUEUE_LOG_ELS   4

// Frame size in bytes
`define RX_FRAME_SIZE_W         12

`endif
